//--- rtl/ooo_defines.svh
/*
 * Width and size macros for the memory issue stage:
 * dispatch lanes, writeback ways, register file, queue depth, load latency
 */

`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

// Micro-ops accepted from dispatch per cycle
`define DISPATCH_WIDTH 2

// Writeback ways into the scoreboard
// Way 0 is the memory pipeline, way 1 the integer ALU
`define PRF_INT_WAYS 2

// Integer physical register file
`define PRF_INT_SIZE 32
`define PRF_INT_INDEX_SIZE 5

// Memory issue queue slots
`define IQ_MEM_SIZE 4

// Cycles from issue to writeback in the memory pipeline
`define LOAD_LATENCY 3

`endif

//--- rtl/ooo_pkg.sv
/*
 * Shared types for the memory issue stage:
 * physical register index and queue slot age
 */

`default_nettype none

`include "ooo_defines.svh"

package ooo_pkg;

  // Physical register index
  typedef logic [`PRF_INT_INDEX_SIZE-1:0] prf_index_t;

  // Relative age of a queue entry, larger means older
  typedef logic [$clog2(`IQ_MEM_SIZE)-1:0] iq_age_t;

endpackage

`default_nettype wire

//--- rtl/prf_scoreboard.sv
/*
 * Physical register busy table, one bank per issue queue slot
 * Set from dispatch, cleared by writeback, with same-cycle bypass
 */

`timescale 1ns/1ps
`default_nettype none

`include "ooo_defines.svh"

module prf_scoreboard
  import ooo_pkg::*;
(
  input  logic                                   clock,
  input  logic                                   rst_n,
  input  logic                                   flush,
  // Destinations of dispatched micro-ops
  input  logic       [`DISPATCH_WIDTH-1:0]       set_busy_valid,
  input  prf_index_t [`DISPATCH_WIDTH-1:0]       set_busy_index,
  // Writeback ways
  input  logic       [`PRF_INT_WAYS-1:0]         clear_busy_valid,
  input  prf_index_t [`PRF_INT_WAYS-1:0]         clear_busy_index,
  // Source queries from the queue slots
  input  prf_index_t [`IQ_MEM_SIZE-1:0]          rs1_index,
  input  prf_index_t [`IQ_MEM_SIZE-1:0]          rs2_index,
  output logic       [`IQ_MEM_SIZE-1:0]          rs1_busy,
  output logic       [`IQ_MEM_SIZE-1:0]          rs2_busy
);

  // One copy of the table per slot keeps the read ports local
  logic [`PRF_INT_SIZE-1:0] bank [`IQ_MEM_SIZE];

  logic [`PRF_INT_SIZE-1:0] set_req;
  logic [`PRF_INT_SIZE-1:0] clear_req;

  // Same-cycle writeback hits per slot source
  logic [`IQ_MEM_SIZE-1:0] rs1_bypass;
  logic [`IQ_MEM_SIZE-1:0] rs2_bypass;

  always_comb begin
    set_req = '0;
    for (int l = 0; l < `DISPATCH_WIDTH; l++) begin
      if (set_busy_valid[l]) begin
        set_req[set_busy_index[l]] = 1'b1;
      end
    end
    // Register 0 is constant and never becomes busy
    set_req[0] = 1'b0;
  end

  always_comb begin
    clear_req = '0;
    for (int w = 0; w < `PRF_INT_WAYS; w++) begin
      if (clear_busy_valid[w]) begin
        clear_req[clear_busy_index[w]] = 1'b1;
      end
    end
  end

  always_comb begin
    for (int s = 0; s < `IQ_MEM_SIZE; s++) begin
      rs1_bypass[s] = 1'b0;
      rs2_bypass[s] = 1'b0;
      for (int w = 0; w < `PRF_INT_WAYS; w++) begin
        if (clear_busy_valid[w] && (clear_busy_index[w] == rs1_index[s])) begin
          rs1_bypass[s] = 1'b1;
        end
        if (clear_busy_valid[w] && (clear_busy_index[w] == rs2_index[s])) begin
          rs2_bypass[s] = 1'b1;
        end
      end
    end
  end

  for (genvar s = 0; s < `IQ_MEM_SIZE; s++) begin : g_bank
    // Clear wins over a set of the same register
    always_ff @(posedge clock) begin
      if (!rst_n || flush) begin
        bank[s] <= '0;
      end else begin
        bank[s] <= (bank[s] | set_req) & ~clear_req;
      end
    end

    assign rs1_busy[s] = (rs1_index[s] != '0) && !rs1_bypass[s] && bank[s][rs1_index[s]];
    assign rs2_busy[s] = (rs2_index[s] != '0) && !rs2_bypass[s] && bank[s][rs2_index[s]];
  end

endmodule

`default_nettype wire

//--- rtl/mem_issue_queue.sv
/*
 * Memory issue queue: slot storage, allocation, age tracking
 * and oldest-ready selection with a registered issue output
 */

`timescale 1ns/1ps
`default_nettype none

`include "ooo_defines.svh"

module mem_issue_queue
  import ooo_pkg::*;
(
  input  logic                              clock,
  input  logic                              rst_n,
  input  logic                              flush,
  // Dispatch lanes
  input  logic       [`DISPATCH_WIDTH-1:0]  dispatch_valid,
  input  prf_index_t [`DISPATCH_WIDTH-1:0]  dispatch_rs1,
  input  prf_index_t [`DISPATCH_WIDTH-1:0]  dispatch_rs2,
  input  prf_index_t [`DISPATCH_WIDTH-1:0]  dispatch_rd,
  output logic                              dispatch_ready,
  // Scoreboard inquiry
  output prf_index_t [`IQ_MEM_SIZE-1:0]     slot_rs1,
  output prf_index_t [`IQ_MEM_SIZE-1:0]     slot_rs2,
  input  logic       [`IQ_MEM_SIZE-1:0]     slot_rs1_busy,
  input  logic       [`IQ_MEM_SIZE-1:0]     slot_rs2_busy,
  // Issue to the memory pipeline
  output logic                              issue_valid,
  output prf_index_t                        issue_rs1,
  output prf_index_t                        issue_rs2,
  output prf_index_t                        issue_rd
);

  localparam int unsigned COUNT_W = $clog2(`IQ_MEM_SIZE + 1);
  localparam int unsigned SLOT_W  = $clog2(`IQ_MEM_SIZE);

  typedef logic [COUNT_W-1:0] count_t;
  typedef logic [SLOT_W-1:0]  slot_idx_t;

  logic       [`IQ_MEM_SIZE-1:0] slot_valid;
  prf_index_t                    slot_rd  [`IQ_MEM_SIZE];
  // Age is the number of held entries younger than this one
  iq_age_t                       slot_age [`IQ_MEM_SIZE];
  iq_age_t                       age_next [`IQ_MEM_SIZE];
  logic       [`IQ_MEM_SIZE-1:0] slot_ready;

  // One-hot target slot per lane
  logic [`DISPATCH_WIDTH-1:0][`IQ_MEM_SIZE-1:0] alloc_mask;
  logic [`DISPATCH_WIDTH-1:0]                   lane_accept;
  iq_age_t                                      lane_age [`DISPATCH_WIDTH];
  iq_age_t                                      accept_count;
  count_t                                       free_count;

  logic      sel_found;
  slot_idx_t sel_slot;
  iq_age_t   sel_age;

  always_comb begin
    free_count = '0;
    for (int s = 0; s < `IQ_MEM_SIZE; s++) begin
      free_count = free_count + count_t'(!slot_valid[s]);
    end
  end

  assign dispatch_ready = (free_count >= count_t'(`DISPATCH_WIDTH));

  // Lowest free slots, lane 0 first
  always_comb begin : alloc
    logic [`IQ_MEM_SIZE-1:0] taken;
    logic                    found;
    taken = slot_valid;
    for (int l = 0; l < `DISPATCH_WIDTH; l++) begin
      alloc_mask[l] = '0;
      found = 1'b0;
      if (dispatch_valid[l]) begin
        for (int s = 0; s < `IQ_MEM_SIZE; s++) begin
          if (!taken[s] && !found) begin
            alloc_mask[l][s] = 1'b1;
            found = 1'b1;
          end
        end
      end
      lane_accept[l] = found;
      taken = taken | alloc_mask[l];
    end
  end

  // A lane is older than every accepted lane after it
  always_comb begin
    accept_count = '0;
    for (int l = `DISPATCH_WIDTH - 1; l >= 0; l--) begin
      lane_age[l] = accept_count;
      accept_count = accept_count + iq_age_t'(lane_accept[l]);
    end
  end

  assign slot_ready = slot_valid & ~slot_rs1_busy & ~slot_rs2_busy;

  // Oldest ready slot wins, ages of valid slots are distinct
  always_comb begin
    sel_found = 1'b0;
    sel_slot  = '0;
    sel_age   = '0;
    for (int s = 0; s < `IQ_MEM_SIZE; s++) begin
      if (slot_ready[s] && (!sel_found || (slot_age[s] > sel_age))) begin
        sel_found = 1'b1;
        sel_slot  = slot_idx_t'(s);
        sel_age   = slot_age[s];
      end
    end
  end

  // Older entries lose one younger peer when a younger slot issues
  always_comb begin
    for (int s = 0; s < `IQ_MEM_SIZE; s++) begin
      age_next[s] = slot_age[s] + accept_count
                  - iq_age_t'(sel_found && (sel_age < slot_age[s]));
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n || flush) begin
      slot_valid  <= '0;
      issue_valid <= 1'b0;
    end else begin
      issue_valid <= sel_found;
      for (int s = 0; s < `IQ_MEM_SIZE; s++) begin
        if (sel_found && (sel_slot == slot_idx_t'(s))) begin
          slot_valid[s] <= 1'b0;
        end
        for (int l = 0; l < `DISPATCH_WIDTH; l++) begin
          if (alloc_mask[l][s]) begin
            slot_valid[s] <= 1'b1;
          end
        end
      end
    end
  end

  // Entry fields and ages, meaningful only while the slot is valid
  always_ff @(posedge clock) begin
    for (int s = 0; s < `IQ_MEM_SIZE; s++) begin
      slot_age[s] <= age_next[s];
      for (int l = 0; l < `DISPATCH_WIDTH; l++) begin
        if (alloc_mask[l][s]) begin
          slot_rs1[s] <= dispatch_rs1[l];
          slot_rs2[s] <= dispatch_rs2[l];
          slot_rd[s]  <= dispatch_rd[l];
          slot_age[s] <= lane_age[l];
        end
      end
    end
    if (sel_found) begin
      issue_rs1 <= slot_rs1[sel_slot];
      issue_rs2 <= slot_rs2[sel_slot];
      issue_rd  <= slot_rd[sel_slot];
    end
  end

endmodule

`default_nettype wire

//--- rtl/mem_load_pipe.sv
/*
 * Fixed-latency memory pipeline carrying issued destinations
 * to writeback way 0
 */

`timescale 1ns/1ps
`default_nettype none

`include "ooo_defines.svh"

module mem_load_pipe
  import ooo_pkg::*;
(
  input  logic       clock,
  input  logic       rst_n,
  input  logic       flush,
  input  logic       issue_valid,
  input  prf_index_t issue_rd,
  output logic       wb_mem_valid,
  output prf_index_t wb_mem_index
);

  localparam int unsigned DEPTH = `LOAD_LATENCY;

  // Stand-in for address and data stages
  logic [DEPTH-1:0] stage_valid;
  prf_index_t       stage_rd [DEPTH];

  always_ff @(posedge clock) begin
    if (!rst_n || flush) begin
      // Everything in flight is dropped
      stage_valid <= '0;
    end else begin
      stage_valid[0] <= issue_valid;
      for (int i = 1; i < DEPTH; i++) begin
        stage_valid[i] <= stage_valid[i-1];
      end
    end
  end

  always_ff @(posedge clock) begin
    stage_rd[0] <= issue_rd;
    for (int i = 1; i < DEPTH; i++) begin
      stage_rd[i] <= stage_rd[i-1];
    end
  end

  assign wb_mem_valid = stage_valid[DEPTH-1];
  assign wb_mem_index = stage_rd[DEPTH-1];

endmodule

`default_nettype wire

//--- rtl/mem_issue_top.sv
/*
 * Memory issue stage top: queue, scoreboard and load pipeline,
 * with the external ALU writeback merged as way 1
 */

`timescale 1ns/1ps
`default_nettype none

`include "ooo_defines.svh"

module mem_issue_top
  import ooo_pkg::*;
(
  input  logic                              clock,
  input  logic                              rst_n,
  input  logic                              flush,
  // Dispatch
  input  logic       [`DISPATCH_WIDTH-1:0]  dispatch_valid,
  input  prf_index_t [`DISPATCH_WIDTH-1:0]  dispatch_rs1,
  input  prf_index_t [`DISPATCH_WIDTH-1:0]  dispatch_rs2,
  input  prf_index_t [`DISPATCH_WIDTH-1:0]  dispatch_rd,
  output logic                              dispatch_ready,
  // ALU writeback
  input  logic                              alu_wb_valid,
  input  prf_index_t                        alu_wb_index,
  // Issue and memory writeback
  output logic                              issue_valid,
  output prf_index_t                        issue_rs1,
  output prf_index_t                        issue_rs2,
  output prf_index_t                        issue_rd,
  output logic                              wb_valid,
  output prf_index_t                        wb_index
);

  prf_index_t [`IQ_MEM_SIZE-1:0]  slot_rs1;
  prf_index_t [`IQ_MEM_SIZE-1:0]  slot_rs2;
  logic       [`IQ_MEM_SIZE-1:0]  slot_rs1_busy;
  logic       [`IQ_MEM_SIZE-1:0]  slot_rs2_busy;
  logic       [`PRF_INT_WAYS-1:0] clear_valid;
  prf_index_t [`PRF_INT_WAYS-1:0] clear_index;

  // Way 0 memory, way 1 ALU
  assign clear_valid = {alu_wb_valid, wb_valid};
  assign clear_index = {alu_wb_index, wb_index};

  mem_issue_queue u_queue (
    .clock          (clock),
    .rst_n          (rst_n),
    .flush          (flush),
    .dispatch_valid (dispatch_valid),
    .dispatch_rs1   (dispatch_rs1),
    .dispatch_rs2   (dispatch_rs2),
    .dispatch_rd    (dispatch_rd),
    .dispatch_ready (dispatch_ready),
    .slot_rs1       (slot_rs1),
    .slot_rs2       (slot_rs2),
    .slot_rs1_busy  (slot_rs1_busy),
    .slot_rs2_busy  (slot_rs2_busy),
    .issue_valid    (issue_valid),
    .issue_rs1      (issue_rs1),
    .issue_rs2      (issue_rs2),
    .issue_rd       (issue_rd)
  );

  prf_scoreboard u_scoreboard (
    .clock            (clock),
    .rst_n            (rst_n),
    .flush            (flush),
    .set_busy_valid   (dispatch_valid),
    .set_busy_index   (dispatch_rd),
    .clear_busy_valid (clear_valid),
    .clear_busy_index (clear_index),
    .rs1_index        (slot_rs1),
    .rs2_index        (slot_rs2),
    .rs1_busy         (slot_rs1_busy),
    .rs2_busy         (slot_rs2_busy)
  );

  mem_load_pipe u_load_pipe (
    .clock        (clock),
    .rst_n        (rst_n),
    .flush        (flush),
    .issue_valid  (issue_valid),
    .issue_rd     (issue_rd),
    .wb_mem_valid (wb_valid),
    .wb_mem_index (wb_index)
  );

endmodule

`default_nettype wire

//--- test/mem_issue_assertions.sv
/*
 * Bound checker for the memory issue stage top with a shadow busy table,
 * issue history, queue occupancy and assertions
 */

`timescale 1ns/1ps
`default_nettype none

`include "ooo_defines.svh"

module mem_issue_assertions
  import ooo_pkg::*;
(
  input  logic                              clock,
  input  logic                              rst_n,
  input  logic                              flush,
  input  logic       [`DISPATCH_WIDTH-1:0]  dispatch_valid,
  input  prf_index_t [`DISPATCH_WIDTH-1:0]  dispatch_rd,
  input  logic                              dispatch_ready,
  input  logic                              alu_wb_valid,
  input  prf_index_t                        alu_wb_index,
  input  logic                              issue_valid,
  input  prf_index_t                        issue_rs1,
  input  prf_index_t                        issue_rs2,
  input  prf_index_t                        issue_rd,
  input  logic                              wb_valid,
  input  prf_index_t                        wb_index
);

  localparam int LAT = `LOAD_LATENCY;

  int fail_count = 0;

  logic [`PRF_INT_SIZE-1:0] shadow;
  // Busy state as seen by the selection one cycle before issue
  logic [`PRF_INT_SIZE-1:0] eff_prev;
  logic [`PRF_INT_SIZE-1:0] set_req;
  logic [`PRF_INT_SIZE-1:0] clr_req;
  logic [LAT-1:0]           hist_valid;
  prf_index_t               hist_rd [LAT];
  // Entries counted from port activity
  logic [3:0]               occ;
  logic [3:0]               lanes;

  always_comb begin
    set_req = '0;
    clr_req = '0;
    lanes   = '0;
    for (int l = 0; l < `DISPATCH_WIDTH; l++) begin
      if (dispatch_valid[l]) begin
        set_req[dispatch_rd[l]] = 1'b1;
        lanes = lanes + 4'd1;
      end
    end
    set_req[0] = 1'b0;
    if (wb_valid) clr_req[wb_index] = 1'b1;
    if (alu_wb_valid) clr_req[alu_wb_index] = 1'b1;
  end

  always_ff @(posedge clock) begin
    if (!rst_n || flush) begin
      shadow     <= '0;
      eff_prev   <= '0;
      hist_valid <= '0;
      occ        <= '0;
    end else begin
      shadow     <= (shadow | set_req) & ~clr_req;
      eff_prev   <= shadow & ~clr_req;
      hist_valid <= {hist_valid[LAT-2:0], issue_valid};
      occ        <= occ + lanes - 4'(issue_valid);
    end
    hist_rd[0] <= issue_rd;
    for (int i = 1; i < LAT; i++) begin
      hist_rd[i] <= hist_rd[i-1];
    end
  end

  a_issue_ready: assert property (@(posedge clock) disable iff (!rst_n)
    issue_valid |-> !eff_prev[issue_rs1] && !eff_prev[issue_rs2])
    else begin
      fail_count++;
      $error("issue with a busy source");
    end

  a_wb_valid: assert property (@(posedge clock) disable iff (!rst_n)
    wb_valid == hist_valid[LAT-1])
    else begin
      fail_count++;
      $error("writeback strobe off the load latency");
    end

  a_wb_index: assert property (@(posedge clock) disable iff (!rst_n)
    wb_valid |-> wb_index == hist_rd[LAT-1])
    else begin
      fail_count++;
      $error("writeback index differs from issued rd");
    end

  a_capacity: assert property (@(posedge clock) disable iff (!rst_n)
    occ <= 4'(`IQ_MEM_SIZE))
    else begin
      fail_count++;
      $error("queue holds more entries than slots");
    end

  a_ready_level: assert property (@(posedge clock) disable iff (!rst_n)
    dispatch_ready == ((`IQ_MEM_SIZE - (int'(occ) - int'(issue_valid))) >= `DISPATCH_WIDTH))
    else begin
      fail_count++;
      $error("dispatch_ready disagrees with free slots");
    end

  a_after_clear: assert property (@(posedge clock) disable iff (!rst_n)
    $past(flush || !rst_n) |-> !issue_valid && !wb_valid && dispatch_ready)
    else begin
      fail_count++;
      $error("state not cleared after flush or reset");
    end

  a_no_stale: assert property (@(posedge clock) disable iff (!rst_n)
    issue_valid |-> occ != 4'd0)
    else begin
      fail_count++;
      $error("issue from an empty queue");
    end

endmodule

`default_nettype wire

//--- test/tb_mem_issue.sv
/*
 * Memory issue stage testbench with clock, reset, directed and
 * LFSR-driven tests, flush, drain, timeout and result lines
 */

`timescale 1ns/1ps
`default_nettype none

`include "ooo_defines.svh"

module tb_mem_issue
  import ooo_pkg::*;
();

  localparam int RAND_CYCLES = 150;
  localparam int DRAIN_MAX   = 200;
  localparam int LIMIT       = 2 + 12 + 20 + 2 * RAND_CYCLES + 10 + DRAIN_MAX + 100;

  logic                             clock = 1'b0;
  logic                             rst_n = 1'b0;
  logic                             flush = 1'b0;
  logic       [`DISPATCH_WIDTH-1:0] dispatch_valid = '0;
  prf_index_t [`DISPATCH_WIDTH-1:0] dispatch_rs1 = '0;
  prf_index_t [`DISPATCH_WIDTH-1:0] dispatch_rs2 = '0;
  prf_index_t [`DISPATCH_WIDTH-1:0] dispatch_rd = '0;
  logic                             dispatch_ready;
  logic                             alu_wb_valid = 1'b0;
  prf_index_t                       alu_wb_index = '0;
  logic                             issue_valid;
  prf_index_t                       issue_rs1;
  prf_index_t                       issue_rs2;
  prf_index_t                       issue_rd;
  logic                             wb_valid;
  prf_index_t                       wb_index;

  logic [31:0] lfsr_state = 32'h591a3a21;
  int errors = 0;
  int mark = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int accepted = 0;
  int issued = 0;
  int cycles = 0;

  mem_issue_top uut (.*);

  bind mem_issue_top mem_issue_assertions u_checker (
    .clock(clock), .rst_n(rst_n), .flush(flush), .dispatch_valid(dispatch_valid),
    .dispatch_rd(dispatch_rd), .dispatch_ready(dispatch_ready),
    .alu_wb_valid(alu_wb_valid), .alu_wb_index(alu_wb_index),
    .issue_valid(issue_valid), .issue_rs1(issue_rs1), .issue_rs2(issue_rs2),
    .issue_rd(issue_rd), .wb_valid(wb_valid), .wb_index(wb_index)
  );

  always #20 clock = ~clock;

  always @(posedge clock) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("timeout after %0d cycles, the run did not complete", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  // Galois LFSR stepped once per bit taken
  function automatic logic take_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = b ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
    return b;
  endfunction

  // Mostly 1 to 7 so that micro-ops depend on each other and sometimes 0
  function automatic prf_index_t pick_reg();
    prf_index_t r;
    r = '0;
    for (int i = 0; i < 3; i++) r[i] = take_bit();
    return r;
  endfunction

  task automatic check_value(input string name, input int got, input int exp);
    assert (got == exp) else begin
      $display("mismatch at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  function automatic int total_errors();
    return errors + uut.u_checker.fail_count;
  endfunction

  task automatic end_test(input string name);
    tests_run++;
    if (total_errors() != mark) tests_failed++;
    $display("test %s: %s", name, (total_errors() == mark) ? "ok" : "failed");
    mark = total_errors();
  endtask

  // Advance one cycle and count issues where outputs are stable
  task automatic step();
    @(negedge clock);
    issued += int'(issue_valid);
  endtask

  task automatic drive_one(input prf_index_t rs1, input prf_index_t rs2, input prf_index_t rd);
    dispatch_valid = 2'b01;
    dispatch_rs1[0] = rs1;
    dispatch_rs2[0] = rs2;
    dispatch_rd[0] = rd;
  endtask

  task automatic drive_random();
    dispatch_valid = '0;
    if (dispatch_ready) begin
      for (int l = 0; l < `DISPATCH_WIDTH; l++) begin
        if (take_bit()) begin
          dispatch_valid[l] = 1'b1;
          dispatch_rs1[l] = pick_reg();
          dispatch_rs2[l] = pick_reg();
          dispatch_rd[l] = pick_reg();
          accepted++;
        end
      end
    end
    alu_wb_valid = take_bit() & take_bit();
    alu_wb_index = pick_reg();
  endtask

  task automatic idle_inputs();
    dispatch_valid = '0;
    alu_wb_valid = 1'b0;
    flush = 1'b0;
  endtask

  initial begin
    repeat (2) step();
    rst_n = 1'b1;
    check_value("issue_valid", issue_valid, 0);
    check_value("wb_valid", wb_valid, 0);
    check_value("dispatch_ready", dispatch_ready, 1);
    end_test("reset");

    // Both sources 0 issue two edges after dispatch
    drive_one(5'd0, 5'd0, 5'd9);
    step();
    idle_inputs();
    check_value("issue_valid", issue_valid, 0);
    step();
    check_value("issue_valid", issue_valid, 1);
    check_value("issue_rd", issue_rd, 9);
    repeat (6) step();
    end_test("zero sources");

    // Self-dependent micro-op waits until the ALU writes its source back
    drive_one(5'd12, 5'd3, 5'd12);
    step();
    idle_inputs();
    repeat (3) step();
    check_value("issue_valid", issue_valid, 0);
    alu_wb_valid = 1'b1;
    alu_wb_index = 5'd12;
    step();
    idle_inputs();
    check_value("issue_valid", issue_valid, 1);
    check_value("issue_rs1", issue_rs1, 12);
    check_value("issue_rs2", issue_rs2, 3);
    check_value("issue_rd", issue_rd, 12);
    repeat (6) step();
    end_test("alu bypass");

    accepted = 0;
    issued = 0;
    repeat (RAND_CYCLES) begin
      drive_random();
      step();
    end
    end_test("random before flush");

    idle_inputs();
    flush = 1'b1;
    step();
    flush = 1'b0;
    accepted = 0;
    issued = 0;
    check_value("issue_valid", issue_valid, 0);
    check_value("wb_valid", wb_valid, 0);
    check_value("dispatch_ready", dispatch_ready, 1);
    repeat (`LOAD_LATENCY + 2) step();
    check_value("issued after flush", issued, 0);
    end_test("flush");

    repeat (RAND_CYCLES) begin
      drive_random();
      step();
    end
    // Drain by writing back every register the tests use
    dispatch_valid = '0;
    for (int n = 0; n < DRAIN_MAX && issued != accepted; n++) begin
      alu_wb_valid = 1'b1;
      alu_wb_index = prf_index_t'(1 + (n % 15));
      step();
    end
    idle_inputs();
    repeat (`LOAD_LATENCY + 2) step();
    check_value("issued", issued, accepted);
    end_test("random after flush and drain");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors());
    if (total_errors() == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+rtl
rtl/ooo_pkg.sv
rtl/prf_scoreboard.sv
rtl/mem_issue_queue.sv
rtl/mem_load_pipe.sv
rtl/mem_issue_top.sv
test/mem_issue_assertions.sv
test/tb_mem_issue.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the memory issue stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_mem_issue -o tb_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/tb_sim +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TEST PASSED"; then
  exit 0
fi
exit 1
